// File: lsu_mem.f
verilog/lsu_mem_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/lsu.sv
verilog/axi_ram.sv
verilog/lsu_mem_top.sv
sim/lsu_assert.sv
sim/lsu_mem_tb.sv

// File: run_lsu_mem.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lsu_mem_tb \
  -f lsu_mem.f -o lsu_mem_sim \
  && ./obj_dir/lsu_mem_sim +verilator+error+limit+1000 \
  | tee /dev/stderr \
  | grep -Fx "Everything OK" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/lsu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_assert (
  input logic                  clk,
  input logic                  rstn,
  input lsu_bus_pkg::ar_chan_t ar,
  input logic                  ar_valid,
  input logic                  ar_ready,
  input logic                  aw_valid,
  input logic                  aw_ready,
  input logic                  w_valid,
  input logic                  w_ready,
  input logic                  b_valid,
  input logic                  b_ready,
  input logic                  st_req_valid,
  input logic                  st_req_ready
);

  // failure count, summed into the testbench result
  int   fails = 0;
  logic aw_done;
  logic w_done;

  // aw and w transferred for the store in flight
  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (b_valid && b_ready) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        aw_done <= 1'b1;
      end
      if (w_valid && w_ready) begin
        w_done <= 1'b1;
      end
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar)))
  else begin
    fails++;
    $error("ar_valid or ar payload changed before ar_ready");
  end

  aw_quiet: assert property (@(posedge clk) disable iff (!rstn)
    aw_done |-> !aw_valid)
  else begin
    fails++;
    $error("aw_valid raised again before the b transfer");
  end

  // the request may only go once both channels are through
  st_accept: assert property (@(posedge clk) disable iff (!rstn)
    (st_req_valid && st_req_ready) |->
      ((aw_done || (aw_valid && aw_ready)) && (w_done || (w_valid && w_ready))))
  else begin
    fails++;
    $error("st_req accepted before aw and w were transferred");
  end

endmodule

`default_nettype wire

// File: sim/lsu_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_tb;

  localparam int MEM_ADDR_W = 10;
  localparam int RD_LAT     = 2;
  localparam int ADDR_BITS  = MEM_ADDR_W + 3;
  localparam int MEM_BYTES  = 1 << ADDR_BITS;
  // about 1200 operations at up to 40 cycles each
  localparam int MAX_CYCLES = 60000;

  logic                    clk;
  logic                    rstn;
  lsu_mem_pkg::load_req_t  ld_req;
  logic                    ld_req_valid;
  logic                    ld_req_ready;
  logic [31:0]             ld_data;
  logic                    ld_resp_valid;
  logic                    ld_resp_ready;
  lsu_mem_pkg::store_req_t st_req;
  logic                    st_req_valid;
  logic                    st_req_ready;
  logic                    st_resp_valid;
  logic                    st_resp_ready;

  // byte model of the ram, little endian
  logic [7:0] model [MEM_BYTES];
  integer     seed;
  int         cycles;
  int         checks;
  int         errors;
  int         test_checks;
  int         test_errors;
  logic       bp_on;
  string      test_name;

  lsu_mem_top #(
    .MEM_ADDR_W (MEM_ADDR_W),
    .RD_LAT     (RD_LAT)
  ) uut (
    .clk           (clk),
    .rstn          (rstn),
    .ld_req        (ld_req),
    .ld_req_valid  (ld_req_valid),
    .ld_req_ready  (ld_req_ready),
    .ld_data       (ld_data),
    .ld_resp_valid (ld_resp_valid),
    .ld_resp_ready (ld_resp_ready),
    .st_req        (st_req),
    .st_req_valid  (st_req_valid),
    .st_req_ready  (st_req_ready),
    .st_resp_valid (st_resp_valid),
    .st_resp_ready (st_resp_ready)
  );

  bind lsu lsu_assert u_lsu_assert (
    .clk          (clk),
    .rstn         (rstn),
    .ar           (ar),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .st_req_valid (st_req_valid),
    .st_req_ready (st_req_ready)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic int pick(input int n);
    pick = $unsigned($random(seed)) % n;
  endfunction

  // random address inside the ram, aligned to the access size
  function automatic logic [ADDR_BITS-1:0] rand_addr(input int bytes);
    logic [ADDR_BITS-1:0] a;
    a = ADDR_BITS'(pick(MEM_BYTES));
    rand_addr = a & ~ADDR_BITS'(bytes - 1);
  endfunction

  function automatic logic [31:0] expect_load(input logic [ADDR_BITS-1:0] addr,
                                              input lsu_mem_pkg::load_func_e func);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] wd;
    b  = model[addr];
    h  = {model[addr + ADDR_BITS'(1)], b};
    wd = {model[addr + ADDR_BITS'(3)], model[addr + ADDR_BITS'(2)], h};
    case (func)
      lsu_mem_pkg::ld_bs: expect_load = {{24{b[7]}}, b};
      lsu_mem_pkg::ld_bu: expect_load = {24'b0, b};
      lsu_mem_pkg::ld_hs: expect_load = {{16{h[15]}}, h};
      lsu_mem_pkg::ld_hu: expect_load = {16'b0, h};
      default:            expect_load = wd;
    endcase
  endfunction

  task automatic model_store(input logic [ADDR_BITS-1:0] addr,
                             input lsu_mem_pkg::store_func_e func, input logic [31:0] data);
    model[addr] = data[7:0];
    if (func != lsu_mem_pkg::st_b) begin
      model[addr + ADDR_BITS'(1)] = data[15:8];
    end
    if (func == lsu_mem_pkg::st_w) begin
      model[addr + ADDR_BITS'(2)] = data[23:16];
      model[addr + ADDR_BITS'(3)] = data[31:24];
    end
  endtask

  task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("Fail %s, %s: expected %08h, actual %08h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("Fail %s, %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic do_load(input logic [ADDR_BITS-1:0] addr,
                         input lsu_mem_pkg::load_func_e func, input string what);
    logic [31:0] held;
    logic        waiting;
    int          stall;
    @(negedge clk);
    ld_req       = '{addr: {{(32-ADDR_BITS){1'b0}}, addr}, func: func};
    ld_req_valid = 1'b1;
    #1;
    while (!ld_req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ld_req_valid  = 1'b0;
    stall         = bp_on ? pick(6) : 0;
    ld_resp_ready = (stall == 0);
    waiting       = 1'b0;
    held          = '0;
    #1;
    // ready only counts down once the response is up
    while (!(ld_resp_valid && ld_resp_ready)) begin
      if (ld_resp_valid) begin
        held    = ld_data;
        waiting = 1'b1;
        stall   = stall - 1;
      end
      @(negedge clk);
      ld_resp_ready = (stall <= 0);
      #1;
      if (waiting) begin
        check_data({what, " held"}, held, ld_data);
      end
    end
    check_data(what, expect_load(addr, func), ld_data);
    @(negedge clk);
    #1;
    check_flag({what, " single response"}, 1'b0, ld_resp_valid);
  endtask

  // second read of the same address waits behind a held response
  task automatic load_under_stall(input logic [ADDR_BITS-1:0] addr,
                                  input lsu_mem_pkg::load_func_e func);
    @(negedge clk);
    ld_req        = '{addr: {{(32-ADDR_BITS){1'b0}}, addr}, func: func};
    ld_req_valid  = 1'b1;
    ld_resp_ready = 1'b0;
    #1;
    while (!ld_req_ready) begin
      @(negedge clk);
      #1;
    end
    // valid stays up as the second request while the first is in flight
    repeat (RD_LAT + 2) begin
      @(negedge clk);
      #1;
      check_flag("ld_req_ready while read pending", 1'b0, ld_req_ready);
    end
    check_flag("ld_resp_valid under stall", 1'b1, ld_resp_valid);
    check_data("first load under stall", expect_load(addr, func), ld_data);
    @(negedge clk);
    ld_resp_ready = 1'b1;
    #1;
    check_flag("ld_req_ready before r transfer", 1'b0, ld_req_ready);
    @(negedge clk);
    #1;
    check_flag("first load single response", 1'b0, ld_resp_valid);
    while (!ld_req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ld_req_valid = 1'b0;
    #1;
    while (!ld_resp_valid) begin
      @(negedge clk);
      #1;
    end
    check_data("second load after stall", expect_load(addr, func), ld_data);
    @(negedge clk);
    #1;
    check_flag("second load single response", 1'b0, ld_resp_valid);
  endtask

  task automatic do_store(input logic [ADDR_BITS-1:0] addr,
                          input lsu_mem_pkg::store_func_e func, input logic [31:0] data,
                          input string what);
    int stall;
    @(negedge clk);
    st_req       = '{addr: {{(32-ADDR_BITS){1'b0}}, addr}, func: func, data: data};
    st_req_valid = 1'b1;
    #1;
    while (!st_req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    st_req_valid = 1'b0;
    model_store(addr, func, data);
    stall         = bp_on ? pick(6) : 0;
    st_resp_ready = (stall == 0);
    #1;
    while (!(st_resp_valid && st_resp_ready)) begin
      if (st_resp_valid) begin
        stall = stall - 1;
      end
      @(negedge clk);
      st_resp_ready = (stall <= 0);
      #1;
    end
    @(negedge clk);
    #1;
    check_flag({what, " single response"}, 1'b0, st_resp_valid);
  endtask

  task automatic random_op();
    lsu_mem_pkg::load_func_e  lf;
    lsu_mem_pkg::store_func_e sf;
    int                       bytes;
    if (pick(2) == 0) begin
      sf    = lsu_mem_pkg::store_func_e'(3'(pick(3)));
      bytes = (sf == lsu_mem_pkg::st_b) ? 1 : (sf == lsu_mem_pkg::st_h) ? 2 : 4;
      do_store(rand_addr(bytes), sf, $random(seed), "store");
    end else begin
      lf = lsu_mem_pkg::load_func_e'(3'(pick(5)));
      case (lf)
        lsu_mem_pkg::ld_bs, lsu_mem_pkg::ld_bu: bytes = 1;
        lsu_mem_pkg::ld_hs, lsu_mem_pkg::ld_hu: bytes = 2;
        default:                                bytes = 4;
      endcase
      do_load(rand_addr(bytes), lf, "load");
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  initial begin
    logic [ADDR_BITS-1:0] addrs [32];
    logic [ADDR_BITS-1:0] a;
    seed          = 91;
    clk           = 1'b0;
    rstn          = 1'b0;
    ld_req        = '0;
    ld_req_valid  = 1'b0;
    ld_resp_ready = 1'b1;
    st_req        = '0;
    st_req_valid  = 1'b0;
    st_resp_ready = 1'b1;
    cycles        = 0;
    checks        = 0;
    errors        = 0;
    bp_on         = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model[i] = 8'h00;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    start_test("after reset");
    #1;
    check_flag("ld_resp_valid", 1'b0, ld_resp_valid);
    check_flag("st_resp_valid", 1'b0, st_resp_valid);
    for (int i = 0; i < 8; i++) begin
      do_load(rand_addr(4), lsu_mem_pkg::ld_w, "cleared word");
    end
    end_test();

    start_test("word round trip");
    for (int i = 0; i < 32; i++) begin
      addrs[i] = rand_addr(4);
      do_store(addrs[i], lsu_mem_pkg::st_w, $random(seed), "st_w");
    end
    for (int i = 0; i < 32; i++) begin
      do_load(addrs[i], lsu_mem_pkg::ld_w, "ld_w");
    end
    end_test();

    start_test("byte and halfword stores");
    for (int i = 0; i < 16; i++) begin
      a = rand_addr(4);
      do_store(a, lsu_mem_pkg::st_w, 32'h8badf00d, "st_w base");
      do_store(a + ADDR_BITS'(pick(4)), lsu_mem_pkg::st_b, $random(seed), "st_b");
      do_store(a + ADDR_BITS'(2 * pick(2)), lsu_mem_pkg::st_h, $random(seed), "st_h");
      do_load(a, lsu_mem_pkg::ld_w, "merged word");
      do_load(a ^ ADDR_BITS'(4), lsu_mem_pkg::ld_w, "other half of beat");
    end
    end_test();

    start_test("extension");
    for (int i = 0; i < 8; i++) begin
      a = rand_addr(8);
      do_store(a, lsu_mem_pkg::st_w, $random(seed), "low word");
      do_store(a + ADDR_BITS'(4), lsu_mem_pkg::st_w, $random(seed), "high word");
      for (int off = 0; off < 8; off++) begin
        do_load(a + ADDR_BITS'(off), lsu_mem_pkg::ld_bs, "ld_bs");
        do_load(a + ADDR_BITS'(off), lsu_mem_pkg::ld_bu, "ld_bu");
        if (off % 2 == 0) begin
          do_load(a + ADDR_BITS'(off), lsu_mem_pkg::ld_hs, "ld_hs");
          do_load(a + ADDR_BITS'(off), lsu_mem_pkg::ld_hu, "ld_hu");
        end
      end
    end
    end_test();

    start_test("back-pressure");
    bp_on = 1'b1;
    for (int i = 0; i < 100; i++) begin
      random_op();
    end
    for (int i = 0; i < 8; i++) begin
      load_under_stall(rand_addr(4), lsu_mem_pkg::ld_w);
    end
    bp_on = 1'b0;
    end_test();

    start_test("random mix");
    for (int i = 0; i < 800; i++) begin
      random_op();
    end
    end_test();

    $display("total: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, uut.u_lsu.u_lsu_assert.fails);
    if (errors == 0 && uut.u_lsu.u_lsu_assert.fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/axi_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram #(
  parameter int MEM_ADDR_W = 10,
  parameter int RD_LAT     = 2
) (
  input  logic                  clk,
  input  logic                  rstn,
  // read channels
  input  lsu_bus_pkg::ar_chan_t ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output lsu_bus_pkg::r_chan_t  r,
  output logic                  r_valid,
  input  logic                  r_ready,
  // write channels
  input  lsu_bus_pkg::aw_chan_t aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  lsu_bus_pkg::w_chan_t  w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output lsu_bus_pkg::b_chan_t  b,
  output logic                  b_valid,
  input  logic                  b_ready
);

  localparam int MEM_WORDS = 1 << MEM_ADDR_W;
  localparam int CNT_W     = $clog2(RD_LAT + 1);

  typedef enum logic [1:0] {
    rd_idle,
    rd_wait,
    rd_resp
  } rd_state_e;

  typedef enum logic [1:0] {
    aw_wait,
    w_wait,
    b_resp
  } wr_state_e;

  // 64-bit words, one per 8-byte address
  logic [63:0]           mem [MEM_WORDS];

  rd_state_e             rd_state;
  logic [CNT_W-1:0]      rd_cnt;
  logic [MEM_ADDR_W-1:0] rd_idx;
  logic [MEM_ADDR_W-1:0] ar_idx;
  logic [63:0]           rd_data;

  wr_state_e             wr_state;
  logic [MEM_ADDR_W-1:0] wr_idx;
  logic                  w_fire;

  // word index above the byte offset, wraps at the memory size
  assign ar_idx = ar.addr[MEM_ADDR_W+2:3];

  assign ar_ready = (rd_state == rd_idle);
  assign r_valid  = (rd_state == rd_resp);
  assign r        = '{data: rd_data, resp: lsu_bus_pkg::okay};

  // read countdown
  // r_valid rises RD_LAT cycles after the ar transfer
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (ar_valid) begin
            if (RD_LAT == 1) begin
              rd_state <= rd_resp;
            end else begin
              rd_state <= rd_wait;
            end
          end
        end
        rd_wait: begin
          if (rd_cnt == CNT_W'(1)) begin
            rd_state <= rd_resp;
          end
        end
        rd_resp: begin
          if (r_ready) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // read address, counter and data word
  // data is sampled on entry to rd_resp and held there
  always_ff @(posedge clk) begin
    if (rd_state == rd_idle && ar_valid) begin
      rd_idx <= ar_idx;
      rd_cnt <= CNT_W'(RD_LAT - 1);
      if (RD_LAT == 1) begin
        rd_data <= mem[ar_idx];
      end
    end else if (rd_state == rd_wait) begin
      rd_cnt <= rd_cnt - CNT_W'(1);
      if (rd_cnt == CNT_W'(1)) begin
        rd_data <= mem[rd_idx];
      end
    end
  end

  // write side, aw always ahead of w
  assign aw_ready = (wr_state == aw_wait);
  assign w_ready  = (wr_state == w_wait);
  assign b_valid  = (wr_state == b_resp);
  assign b        = '{resp: lsu_bus_pkg::okay};
  assign w_fire   = w_valid && w_ready;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= aw_wait;
    end else begin
      case (wr_state)
        aw_wait: begin
          if (aw_valid) begin
            wr_state <= w_wait;
          end
        end
        w_wait: begin
          if (w_valid) begin
            wr_state <= b_resp;
          end
        end
        b_resp: begin
          if (b_ready) begin
            wr_state <= aw_wait;
          end
        end
        default: wr_state <= aw_wait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_state == aw_wait && aw_valid) begin
      wr_idx <= aw.addr[MEM_ADDR_W+2:3];
    end
  end

  // clear on reset, otherwise merge under the strobe
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (w_fire) begin
      for (int n = 0; n < 8; n++) begin
        if (w.strb[n]) begin
          mem[wr_idx][n*8 +: 8] <= w.data[n*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  logic                    clk,
  input  logic                    rstn,
  // core load request and response
  input  lsu_mem_pkg::load_req_t  ld_req,
  input  logic                    ld_req_valid,
  output logic                    ld_req_ready,
  output logic [31:0]             ld_data,
  output logic                    ld_resp_valid,
  input  logic                    ld_resp_ready,
  // core store request and response
  input  lsu_mem_pkg::store_req_t st_req,
  input  logic                    st_req_valid,
  output logic                    st_req_ready,
  output logic                    st_resp_valid,
  input  logic                    st_resp_ready,
  // memory read channels
  output lsu_bus_pkg::ar_chan_t   ar,
  output logic                    ar_valid,
  input  logic                    ar_ready,
  input  lsu_bus_pkg::r_chan_t    r,
  input  logic                    r_valid,
  output logic                    r_ready,
  // memory write channels
  output lsu_bus_pkg::aw_chan_t   aw,
  output logic                    aw_valid,
  input  logic                    aw_ready,
  output lsu_bus_pkg::w_chan_t    w,
  output logic                    w_valid,
  input  logic                    w_ready,
  input  lsu_bus_pkg::b_chan_t    b,
  input  logic                    b_valid,
  output logic                    b_ready
);

  // load path state, captured on the ar transfer
  logic [2:0]              ld_off_q;
  lsu_mem_pkg::load_func_e ld_func_q;
  logic [2:0]              ar_size;
  logic [63:0]             r_shifted;
  logic                    ar_fire;

  // store path
  logic [2:0]              aw_size;
  logic [7:0]              st_mask;
  logic [7:0]              st_strb;
  logic [63:0]             st_lane_data;
  logic                    aw_flag;
  logic                    w_flag;
  logic                    aw_fire;
  logic                    w_fire;
  logic                    b_fire;

  // load request goes straight to ar
  assign ar_valid     = ld_req_valid;
  assign ld_req_ready = ar_ready;
  assign ar_fire      = ar_valid && ar_ready;

  always_comb begin
    case (ld_req.func)
      lsu_mem_pkg::ld_bs, lsu_mem_pkg::ld_bu: ar_size = 3'd0;
      lsu_mem_pkg::ld_hs, lsu_mem_pkg::ld_hu: ar_size = 3'd1;
      default:                                ar_size = 3'd2;
    endcase
  end

  assign ar = '{addr: ld_req.addr, size: ar_size};

  // byte offset and function are needed again when the data returns
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      ld_off_q  <= ld_req.addr[2:0];
      ld_func_q <= ld_req.func;
    end
  end

  // bring the addressed byte down to bit 0
  assign r_shifted = r.data >> {ld_off_q, 3'b000};

  always_comb begin
    case (ld_func_q)
      lsu_mem_pkg::ld_bs: ld_data = {{24{r_shifted[7]}}, r_shifted[7:0]};
      lsu_mem_pkg::ld_bu: ld_data = {24'b0, r_shifted[7:0]};
      lsu_mem_pkg::ld_hs: ld_data = {{16{r_shifted[15]}}, r_shifted[15:0]};
      lsu_mem_pkg::ld_hu: ld_data = {16'b0, r_shifted[15:0]};
      default:            ld_data = r_shifted[31:0];
    endcase
  end

  // r and the load response are one handshake
  // r.resp is always okay from this memory
  assign ld_resp_valid = r_valid;
  assign r_ready       = ld_resp_ready;

  // size and unshifted mask per store function
  always_comb begin
    case (st_req.func)
      lsu_mem_pkg::st_b: begin
        aw_size = 3'd0;
        st_mask = 8'h01;
      end
      lsu_mem_pkg::st_h: begin
        aw_size = 3'd1;
        st_mask = 8'h03;
      end
      default: begin
        aw_size = 3'd2;
        st_mask = 8'h0f;
      end
    endcase
  end

  // move data and strobe into their byte lanes
  assign st_lane_data = {32'b0, st_req.data} << {st_req.addr[2:0], 3'b000};
  assign st_strb      = st_mask << st_req.addr[2:0];

  assign aw = '{addr: st_req.addr, size: aw_size};
  assign w  = '{data: st_lane_data, strb: st_strb};

  // each channel fires once per store request
  assign aw_valid = st_req_valid && aw_flag;
  assign w_valid  = st_req_valid && w_flag;
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;
  assign b_fire   = b_valid && b_ready;

  // accepted once both channels are done or finishing this cycle
  assign st_req_ready = (aw_ready || !aw_flag) && (w_ready || !w_flag);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_flag <= 1'b1;
      w_flag  <= 1'b1;
    end else if (b_fire) begin
      // rearm for the next store
      aw_flag <= 1'b1;
      w_flag  <= 1'b1;
    end else begin
      if (aw_fire) begin
        aw_flag <= 1'b0;
      end
      if (w_fire) begin
        w_flag <= 1'b0;
      end
    end
  end

  // b.resp carries no error from this memory
  assign st_resp_valid = b_valid;
  assign b_ready       = st_resp_ready;

endmodule

`default_nettype wire

// File: verilog/lsu_bus_pkg.sv
`default_nettype none

package lsu_bus_pkg;

  // response codes on r and b
  // the ram only ever answers okay
  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } resp_e;

  // read address channel
  // size is log2 of the byte count
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } ar_chan_t;

  // read data channel, whole 64-bit beat
  typedef struct packed {
    logic [63:0] data;
    resp_e       resp;
  } r_chan_t;

  // write address channel
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } aw_chan_t;

  // write data channel
  // strb bit n enables byte n of data
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
  } w_chan_t;

  // write response channel
  typedef struct packed {
    resp_e resp;
  } b_chan_t;

endpackage

`default_nettype wire

// File: verilog/lsu_mem_pkg.sv
`default_nettype none

package lsu_mem_pkg;

  // load functions as seen on the core side
  // byte and halfword come in signed and unsigned flavours
  typedef enum logic [2:0] {
    ld_bs = 3'd0,
    ld_bu = 3'd1,
    ld_hs = 3'd2,
    ld_hu = 3'd3,
    ld_w  = 3'd4
  } load_func_e;

  // store functions
  typedef enum logic [2:0] {
    st_b = 3'd0,
    st_h = 3'd1,
    st_w = 3'd2
  } store_func_e;

  // load request payload, 35 bits
  typedef struct packed {
    logic [31:0] addr;
    load_func_e  func;
  } load_req_t;

  // store request payload, 67 bits
  // data is right aligned, lane placement happens in the lsu
  typedef struct packed {
    logic [31:0] addr;
    store_func_e func;
    logic [31:0] data;
  } store_req_t;

endpackage

`default_nettype wire

// File: verilog/lsu_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_top #(
  parameter int MEM_ADDR_W = 10,
  parameter int RD_LAT     = 2
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  lsu_mem_pkg::load_req_t  ld_req,
  input  logic                    ld_req_valid,
  output logic                    ld_req_ready,
  output logic [31:0]             ld_data,
  output logic                    ld_resp_valid,
  input  logic                    ld_resp_ready,
  input  lsu_mem_pkg::store_req_t st_req,
  input  logic                    st_req_valid,
  output logic                    st_req_ready,
  output logic                    st_resp_valid,
  input  logic                    st_resp_ready
);

  // lsu to ram channels
  lsu_bus_pkg::ar_chan_t ar;
  lsu_bus_pkg::r_chan_t  r;
  lsu_bus_pkg::aw_chan_t aw;
  lsu_bus_pkg::w_chan_t  w;
  lsu_bus_pkg::b_chan_t  b;
  logic                  ar_valid;
  logic                  ar_ready;
  logic                  r_valid;
  logic                  r_ready;
  logic                  aw_valid;
  logic                  aw_ready;
  logic                  w_valid;
  logic                  w_ready;
  logic                  b_valid;
  logic                  b_ready;

  lsu u_lsu (
    .clk           (clk),
    .rstn          (rstn),
    .ld_req        (ld_req),
    .ld_req_valid  (ld_req_valid),
    .ld_req_ready  (ld_req_ready),
    .ld_data       (ld_data),
    .ld_resp_valid (ld_resp_valid),
    .ld_resp_ready (ld_resp_ready),
    .st_req        (st_req),
    .st_req_valid  (st_req_valid),
    .st_req_ready  (st_req_ready),
    .st_resp_valid (st_resp_valid),
    .st_resp_ready (st_resp_ready),
    .ar            (ar),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r             (r),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b             (b),
    .b_valid       (b_valid),
    .b_ready       (b_ready)
  );

  axi_ram #(
    .MEM_ADDR_W (MEM_ADDR_W),
    .RD_LAT     (RD_LAT)
  ) u_ram (
    .clk      (clk),
    .rstn     (rstn),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready)
  );

endmodule

`default_nettype wire
